// File: files.f
+incdir+.
rv_isa_pkg.sv
bpu_pkg.sv
inst_predecode.sv
tage_predictor.sv
btb.sv
return_stack.sv
next_pc_select.sv
bpu_top.sv
tb_clk_gen.sv
tb_bpu.sv

// File: Bender.yml
package:
  name: bpu

sources:
  - files:
      - rv_isa_pkg.sv
      - bpu_pkg.sv
      - inst_predecode.sv
      - tage_predictor.sv
      - btb.sv
      - return_stack.sv
      - next_pc_select.sv
      - bpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_bpu.sv

// File: tb_bpu_model.svh
// shadow copy of every table, the BTB, the stack and the history
ctr_t     bim_ctrs  [bim_entries];
ctr_t     t0_ctrs   [tage_entries];
tag_t     t0_tags   [tage_entries];
ctr_t     t1_ctrs   [tage_entries];
tag_t     t1_tags   [tage_entries];
logic     btb_valid [btb_entries];
btb_tag_t btb_tags  [btb_entries];
addr_t    btb_tgts  [btb_entries];
addr_t    stack_m   [$];   // back of the queue is the stack top
hist_t    hist_m;

task automatic clear_state();
    for (int i = 0; i < bim_entries; i++) begin
        bim_ctrs[i] = 2'b01;
    end
    for (int i = 0; i < tage_entries; i++) begin
        t0_ctrs[i] = 2'b01;
        t1_ctrs[i] = 2'b01;
        t0_tags[i] = '0;
        t1_tags[i] = '0;
    end
    for (int i = 0; i < btb_entries; i++) begin
        btb_valid[i] = 1'b0;
    end
    stack_m.delete();
    hist_m = '0;
endtask

function automatic ctr_t sat_step(ctr_t c, logic t);
    if (t) begin
        return (c == 2'b11) ? c : c + 2'd1;
    end
    return (c == 2'b00) ? c : c - 2'd1;
endfunction

function automatic tage_idx_t t0_index(addr_t pc, hist_t h);
    return pc[7:0] ^ h[7:0];
endfunction

function automatic tage_idx_t t1_index(addr_t pc, hist_t h);
    return pc[7:0] ^ h[15:8];
endfunction

function automatic tag_t t0_tag_of(addr_t pc, hist_t h);
    return pc[17:8] ^ h[15:6];
endfunction

function automatic tag_t t1_tag_of(addr_t pc, hist_t h);
    return pc[17:8] ^ {2'b00, h[7:0]};
endfunction

// 2 = T1, 1 = T0, 0 = bimodal
function automatic int provider_of(addr_t pc, hist_t h);
    tag_t stored1;
    tag_t probe1;
    tag_t stored0;
    tag_t probe0;
    stored1 = t1_tags[t1_index(pc, h)];
    probe1  = t1_tag_of(pc, h);
    stored0 = t0_tags[t0_index(pc, h)];
    probe0  = t0_tag_of(pc, h);
    if (stored1[9:4] == probe1[9:4]) begin
        return 2;
    end
    if (stored0[9:4] == probe0[9:4]) begin
        return 1;
    end
    return 0;
endfunction

function automatic logic direction_of(addr_t pc, hist_t h);
    case (provider_of(pc, h))
        2:       return t1_ctrs[t1_index(pc, h)][1];
        1:       return t0_ctrs[t0_index(pc, h)][1];
        default: return bim_ctrs[pc[9:1]][1];
    endcase
endfunction

function automatic inst_class_t decode_inst(inst_t inst);
    inst_class_t c;
    c.is_branch = (inst[6:0] == opc_branch);
    c.is_jal    = (inst[6:0] == opc_jal);
    c.is_jalr   = (inst[6:0] == opc_jalr);
    c.is_ret    = c.is_jalr && (inst[19:15] == 5'd1 || inst[19:15] == 5'd5) &&
                  (inst[11:7] == 5'd0) && (inst[31:20] == 12'd0);
    c.b_offset  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    c.j_offset  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return c;
endfunction

function automatic bpu_pred_t predict_next(addr_t pc, inst_t inst);
    inst_class_t c;
    bpu_pred_t   p;
    logic        hit;
    logic        dir;
    c      = decode_inst(inst);
    hit    = btb_valid[pc[9:2]] && (btb_tags[pc[9:2]] == pc[31:10]);
    dir    = direction_of(pc, hist_m);
    p.is_cf  = c.is_branch || c.is_jal || c.is_jalr;
    p.taken  = 1'b0;
    p.target = pc + 32'd4;
    if (c.is_ret) begin
        if (stack_m.size() > 0) begin
            p.taken  = 1'b1;
            p.target = stack_m[$];
        end
    end else if (c.is_jal) begin
        p.taken  = 1'b1;
        p.target = hit ? btb_tgts[pc[9:2]] : pc + c.j_offset;
    end else if ((c.is_branch || c.is_jalr) && dir) begin
        p.taken = 1'b1;
        if (hit) begin
            p.target = btb_tgts[pc[9:2]];
        end else if (c.is_branch) begin
            p.target = pc + c.b_offset;
        end
    end
    return p;
endfunction

// one rising edge worth of training and stack traffic
task automatic apply_update(input bpu_update_t u, input inst_t xi, input logic push,
                            input addr_t paddr, input logic stl);
    int          prov;
    tage_idx_t   i0;
    tage_idx_t   i1;
    tag_t        g0;
    tag_t        g1;
    bim_idx_t    bi;
    btb_idx_t    bx;
    inst_class_t xc;
    prov = provider_of(u.pc, u.history);
    i0   = t0_index(u.pc, u.history);
    i1   = t1_index(u.pc, u.history);
    g0   = t0_tag_of(u.pc, u.history);
    g1   = t1_tag_of(u.pc, u.history);
    bi   = u.pc[9:1];
    bx   = u.pc[9:2];
    xc   = decode_inst(xi);
    if (u.valid) begin
        bim_ctrs[bi] = sat_step(bim_ctrs[bi], u.taken);
        if (prov == 2) begin
            t1_ctrs[i1] = u.correct ? sat_step(t1_ctrs[i1], u.taken) : {2{u.taken}};
        end else if (prov == 1) begin
            t0_ctrs[i0] = u.correct ? sat_step(t0_ctrs[i0], u.taken) : {2{u.taken}};
        end else if (!u.correct) begin
            if (t1_tags[i1] != g1) begin
                t1_tags[i1] = g1;
                t1_ctrs[i1] = u.taken ? 2'b10 : 2'b01;
            end else if (t0_tags[i0] != g0) begin
                t0_tags[i0] = g0;
                t0_ctrs[i0] = u.taken ? 2'b10 : 2'b01;
            end
        end
        hist_m = {hist_m[14:0], u.taken};
        if (u.taken) begin
            btb_valid[bx] = 1'b1;
            btb_tags[bx]  = u.pc[31:10];
            btb_tgts[bx]  = u.target;
        end
    end
    if (!stl) begin
        if (u.valid && u.taken && xc.is_ret && stack_m.size() > 0) begin
            void'(stack_m.pop_back());
        end
        if (push && stack_m.size() < ras_depth) begin
            stack_m.push_back(paddr);
        end
    end
endtask

// File: tb_bpu.sv
`timescale 1ns/1ns

module tb_bpu
    import rv_isa_pkg::*;
    import bpu_pkg::*;
;

    localparam int ras_depth    = 8;    // small so the full stack is reached
    localparam int total_cycles = 664;  // reset plus all tests
    localparam int timeout_ns   = (total_cycles + 50) * 100;

    logic        clk;
    logic        rst;
    addr_t       if_pc;
    inst_t       if_inst;
    bpu_update_t ex_upd;
    inst_t       ex_inst;
    logic        id_push;
    addr_t       id_push_addr;
    logic        stall;
    bpu_pred_t   pred;
    hist_t       history;

    int    seed = 32'h03305a1d;
    addr_t pool [16];
    int    test_errs;
    int    total_errs;
    int    tests_run;
    int    tests_failed;

    `include "tb_bpu_model.svh"

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    bpu_top #(
        .ras_depth (ras_depth)
    ) bpu_top_i (
        .clk            (clk),
        .rst            (rst),
        .if_pc_i        (if_pc),
        .if_inst_i      (if_inst),
        .ex_update_i    (ex_upd),
        .ex_inst_i      (ex_inst),
        .id_push_i      (id_push),
        .id_push_addr_i (id_push_addr),
        .stall_i        (stall),
        .pred_o         (pred),
        .history_o      (history)
    );

    function automatic logic coin(int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    function automatic addr_t pick_pc();
        int r;
        r = $random(seed);
        return pool[r[3:0]];
    endfunction

    function automatic inst_t alu_inst();
        inst_t w;
        w = $random(seed);
        w[6:0] = w[7] ? 7'b0010011 : 7'b0110011;  // op-imm or op
        return w;
    endfunction

    // feedback built from the model's own history and direction
    task automatic set_update(input logic valid, input logic taken, input addr_t pc);
        ex_upd.valid   = valid;
        ex_upd.taken   = taken;
        ex_upd.pc      = pc;
        ex_upd.history = hist_m;
        ex_upd.correct = (direction_of(pc, hist_m) == taken);
        ex_upd.target  = $random(seed) & 32'h000f_fffc;
    endtask

    // called at a falling edge with the inputs already driven
    task automatic run_cycle(input string name);
        bpu_pred_t exp;
        #10;
        exp = predict_next(if_pc, if_inst);
        if (pred !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, pred);
            test_errs++;
        end
        if (history !== hist_m) begin
            $display("ERR %s history expected %h actual %h", name, hist_m, history);
            test_errs++;
        end
        @(posedge clk);
        apply_update(ex_upd, ex_inst, id_push, id_push_addr, stall);
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s with %0d errors", name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        tests_run++;
        test_errs = 0;
    endtask

    task automatic test_history();
        if (history !== '0) begin
            $display("ERR history expected %h actual %h", 16'h0, history);
            test_errs++;
        end
        for (int i = 0; i < 60; i++) begin
            if_pc   = pick_pc();
            if_inst = alu_inst();
            ex_inst = alu_inst();
            set_update((i >= 10) && coin(2), coin(2), pick_pc());  // idle first
            run_cycle("history");
        end
        end_test("history");
    endtask

    task automatic test_non_cf();
        for (int i = 0; i < 40; i++) begin
            if_pc   = pick_pc();
            if_inst = alu_inst();
            ex_inst = alu_inst();
            set_update(1'b0, 1'b0, if_pc);
            run_cycle("non_cf");
        end
        end_test("non_cf");
    endtask

    task automatic test_branch_dir();
        inst_t w;
        for (int i = 0; i < 300; i++) begin
            w       = $random(seed);
            w[6:0]  = coin(4) ? opc_jalr : opc_branch;  // jalr shares the direction path
            if_pc   = pick_pc();
            if_inst = w;
            ex_inst = w;
            set_update(!coin(8), coin(2), if_pc);
            run_cycle("branch_dir");
        end
        end_test("branch_dir");
    endtask

    task automatic test_jal_target();
        addr_t pc;
        inst_t w;
        for (int k = 0; k < 20; k++) begin
            pc      = pick_pc() | 32'h0040_0000;  // tag region not trained yet
            w       = $random(seed);
            w[6:0]  = opc_jal;
            if_pc   = pc;
            if_inst = w;
            ex_inst = alu_inst();
            set_update(1'b0, 1'b0, pc);
            run_cycle("jal_target");
            set_update(1'b1, 1'b1, pc);
            run_cycle("jal_target");
            set_update(1'b0, 1'b0, pc);
            run_cycle("jal_target");  // btb hit from here on
        end
        end_test("jal_target");
    endtask

    task automatic test_ras();
        logic pop;
        for (int i = 0; i < 200; i++) begin
            if_pc        = pick_pc();
            if_inst      = coin(2) ? 32'h00008067 : 32'h00028067;  // ret via ra or t0
            if (coin(5)) begin
                if_inst[6:0] = opc_branch;
            end
            pop          = (i < 100) ? coin(5) : coin(2);  // fill first, then drain
            id_push      = (i < 100) ? coin(2) : coin(5);
            id_push_addr = $random(seed) & 32'hffff_fffc;
            stall        = coin(4);
            ex_inst      = pop ? 32'h00008067 : alu_inst();
            if (pop) begin
                set_update(1'b1, 1'b1, pick_pc());
            end else begin
                set_update(coin(2), coin(2), pick_pc());
            end
            run_cycle("ras");
        end
        id_push = 1'b0;
        stall   = 1'b0;
        end_test("ras");
    endtask

    initial begin
        clear_state();
        if_pc        = '0;
        if_inst      = '0;
        ex_upd       = '0;
        ex_inst      = '0;
        id_push      = 1'b0;
        id_push_addr = '0;
        stall        = 1'b0;
        test_errs    = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 16; i++) begin
            pool[i] = $random(seed) & 32'h0003_fffc;
        end

        wait (rst == 1'b0);
        @(negedge clk);

        test_history();
        test_non_cf();
        test_branch_dir();
        test_jal_target();
        test_ras();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int period     = 100,
    parameter int rst_cycles = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period / 2) clk_o = ~clk_o;
    end

    // release a quarter period after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (rst_cycles) @(posedge clk_o);
        #(period / 4);
        rst_o = 1'b0;
    end

endmodule

// File: bpu_top.sv
`timescale 1ns/1ns

module bpu_top
    import rv_isa_pkg::*;
    import bpu_pkg::*;
#(
    parameter int ras_depth = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  addr_t       if_pc_i,
    input  inst_t       if_inst_i,
    input  bpu_update_t ex_update_i,
    input  inst_t       ex_inst_i,
    input  logic        id_push_i,
    input  addr_t       id_push_addr_i,
    input  logic        stall_i,
    output bpu_pred_t   pred_o,
    output hist_t       history_o
);

    inst_class_t if_class;
    inst_class_t ex_class;
    logic        dir_taken;
    logic        btb_hit;
    addr_t       btb_target;
    logic        ras_pop;
    logic        ras_valid;
    addr_t       ras_top;

    inst_predecode u_if_predecode (
        .inst_i  (if_inst_i),
        .class_o (if_class)
    );

    // same decoder on the executed instruction, only is_ret is needed
    inst_predecode u_ex_predecode (
        .inst_i  (ex_inst_i),
        .class_o (ex_class)
    );

    tage_predictor u_tage (
        .clk       (clk),
        .rst       (rst),
        .pc_i      (if_pc_i),
        .update_i  (ex_update_i),
        .taken_o   (dir_taken),
        .history_o (history_o)
    );

    btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (if_pc_i),
        .update_i (ex_update_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    assign ras_pop = ex_update_i.valid && ex_update_i.taken && ex_class.is_ret;

    return_stack #(
        .ras_depth (ras_depth)
    ) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_push_i),
        .push_addr_i (id_push_addr_i),
        .pop_i       (ras_pop),
        .stall_i     (stall_i),
        .valid_o     (ras_valid),
        .top_o       (ras_top)
    );

    next_pc_select u_sel (
        .pc_i         (if_pc_i),
        .class_i      (if_class),
        .dir_taken_i  (dir_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_valid_i  (ras_valid),
        .ras_top_i    (ras_top),
        .pred_o       (pred_o)
    );

endmodule

// File: next_pc_select.sv
`timescale 1ns/1ns

module next_pc_select
    import rv_isa_pkg::*;
    import bpu_pkg::*;
(
    input  addr_t       pc_i,
    input  inst_class_t class_i,
    input  logic        dir_taken_i,
    input  logic        btb_hit_i,
    input  addr_t       btb_target_i,
    input  logic        ras_valid_i,
    input  addr_t       ras_top_i,
    output bpu_pred_t   pred_o
);

    addr_t pc_plus4;

    assign pc_plus4 = pc_i + addr_t'(4);

    always_comb begin
        pred_o.is_cf  = class_i.is_branch || class_i.is_jal || class_i.is_jalr;
        pred_o.taken  = 1'b0;
        pred_o.target = pc_plus4;

        if (class_i.is_ret) begin
            // empty stack falls through
            pred_o.taken = ras_valid_i;
            if (ras_valid_i) begin
                pred_o.target = ras_top_i;
            end
        end else if (class_i.is_jal) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit_i ? btb_target_i : pc_i + class_i.j_offset;
        end else if (class_i.is_branch || class_i.is_jalr) begin
            pred_o.taken = dir_taken_i;
            if (dir_taken_i) begin
                if (btb_hit_i) begin
                    pred_o.target = btb_target_i;
                end else if (class_i.is_branch) begin
                    pred_o.target = pc_i + class_i.b_offset;
                end
                // jalr without a btb hit keeps pc+4
            end
        end
    end

endmodule

// File: return_stack.sv
`timescale 1ns/1ns

module return_stack
    import rv_isa_pkg::*;
#(
    parameter int ras_depth = 32
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  addr_t push_addr_i,
    input  logic  pop_i,
    input  logic  stall_i,
    output logic  valid_o,
    output addr_t top_o
);

    // pointer must reach ras_depth itself to mark full
    localparam int ptr_w = $clog2(ras_depth + 1);
    localparam int idx_w = (ras_depth > 1) ? $clog2(ras_depth) : 1;

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [idx_w-1:0] idx_t;

    addr_t stack_q [ras_depth];
    ptr_t  sp_q;           // next free slot
    ptr_t  sp_popped;      // pointer after the pop step
    ptr_t  sp_d;
    logic  do_push;
    idx_t  top_idx;

    always_comb begin
        sp_popped = sp_q;
        if (pop_i && sp_q != '0) begin
            sp_popped = sp_q - 1'b1;
        end
        do_push = push_i && (sp_popped != ptr_t'(ras_depth));  // full drops the push
        sp_d    = do_push ? sp_popped + 1'b1 : sp_popped;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else if (!stall_i) begin
            sp_q <= sp_d;
        end
    end

    // push lands on the slot the pop just freed
    always_ff @(posedge clk) begin
        if (!stall_i && do_push) begin
            stack_q[idx_t'(sp_popped)] <= push_addr_i;
        end
    end

    assign top_idx = idx_t'(sp_q - 1'b1);
    assign valid_o = (sp_q != '0);
    assign top_o   = stack_q[top_idx];

endmodule

// File: btb.sv
`timescale 1ns/1ns

module btb
    import rv_isa_pkg::*;
    import bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  addr_t       pc_i,
    input  bpu_update_t update_i,
    output logic        hit_o,
    output addr_t       target_o
);

    btb_tag_t                tag_q    [btb_entries];
    addr_t                   target_q [btb_entries];
    logic [btb_entries-1:0]  valid_q;

    btb_idx_t lk_idx, up_idx;
    btb_tag_t lk_tag, up_tag;
    logic     fill;

    // word aligned index, tag is everything above it
    assign lk_idx = pc_i[9:2];
    assign lk_tag = pc_i[xlen-1 -: btb_tag_len];
    assign up_idx = update_i.pc[9:2];
    assign up_tag = update_i.pc[xlen-1 -: btb_tag_len];

    assign fill = update_i.valid && update_i.taken;  // only taken branches

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[up_idx]    <= up_tag;
            target_q[up_idx] <= update_i.target;
        end
    end

    assign hit_o    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign target_o = target_q[lk_idx];

endmodule

// File: tage_predictor.sv
`timescale 1ns/1ns

module tage_predictor
    import rv_isa_pkg::*;
    import bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  addr_t       pc_i,
    input  bpu_update_t update_i,
    output logic        taken_o,
    output hist_t       history_o
);

    // all indices and tags derived from one pc/history pair
    typedef struct packed {
        bim_idx_t  bim_idx;
        tage_idx_t t0_idx;
        tage_idx_t t1_idx;
        tag_t      t0_tag;
        tag_t      t1_tag;
    } tage_key_t;

    ctr_t  bim_ctr [bim_entries];
    ctr_t  t0_ctr  [tage_entries];
    tag_t  t0_tag  [tage_entries];
    ctr_t  t1_ctr  [tage_entries];
    tag_t  t1_tag  [tage_entries];
    hist_t hist_q;

    tage_key_t lk;      // fetch side
    tage_key_t up;      // execute side
    logic      lk_t0_hit, lk_t1_hit;
    logic      up_t0_hit, up_t1_hit;

    function automatic tage_key_t make_key(addr_t pc, hist_t h);
        tage_key_t k;
        k.bim_idx = pc[9:1];
        k.t0_idx  = pc[7:0] ^ h[7:0];
        k.t1_idx  = pc[7:0] ^ h[15:8];
        k.t0_tag  = pc[17:8] ^ h[15:6];
        k.t1_tag  = pc[17:8] ^ tag_t'(h[7:0]);  // low byte, zero extended
        return k;
    endfunction

    function automatic logic part_match(tag_t stored, tag_t probe);
        return stored[tag_len-1 -: partial_tag_bits] == probe[tag_len-1 -: partial_tag_bits];
    endfunction

    assign lk = make_key(pc_i, hist_q);
    assign up = make_key(update_i.pc, update_i.history);

    assign lk_t0_hit = part_match(t0_tag[lk.t0_idx], lk.t0_tag);
    assign lk_t1_hit = part_match(t1_tag[lk.t1_idx], lk.t1_tag);
    assign up_t0_hit = part_match(t0_tag[up.t0_idx], up.t0_tag);
    assign up_t1_hit = part_match(t1_tag[up.t1_idx], up.t1_tag);

    // longest history wins
    always_comb begin
        if (lk_t1_hit) begin
            taken_o = t1_ctr[lk.t1_idx][1];
        end else if (lk_t0_hit) begin
            taken_o = t0_ctr[lk.t0_idx][1];
        end else begin
            taken_o = bim_ctr[lk.bim_idx][1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bim_entries; i++) begin
                bim_ctr[i] <= ctr_weak_nt;
            end
            for (int i = 0; i < tage_entries; i++) begin
                t0_ctr[i] <= ctr_weak_nt;
                t0_tag[i] <= '0;
                t1_ctr[i] <= ctr_weak_nt;
                t1_tag[i] <= '0;
            end
        end else if (update_i.valid) begin
            bim_ctr[up.bim_idx] <= ctr_next(bim_ctr[up.bim_idx], update_i.taken);

            if (up_t1_hit) begin
                t1_ctr[up.t1_idx] <= update_i.correct ?
                                     ctr_next(t1_ctr[up.t1_idx], update_i.taken) :
                                     ctr_strong(update_i.taken);
            end else if (up_t0_hit) begin
                t0_ctr[up.t0_idx] <= update_i.correct ?
                                     ctr_next(t0_ctr[up.t0_idx], update_i.taken) :
                                     ctr_strong(update_i.taken);
            end else if (!update_i.correct) begin
                // bimodal missed, try to allocate a tagged entry
                if (t1_tag[up.t1_idx] != up.t1_tag) begin
                    t1_tag[up.t1_idx] <= up.t1_tag;
                    t1_ctr[up.t1_idx] <= ctr_weak(update_i.taken);
                end else if (t0_tag[up.t0_idx] != up.t0_tag) begin
                    t0_tag[up.t0_idx] <= up.t0_tag;
                    t0_ctr[up.t0_idx] <= ctr_weak(update_i.taken);
                end
            end
        end
    end

    // global history, newest outcome in bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (update_i.valid) begin
            hist_q <= {hist_q[hist_len-2:0], update_i.taken};
        end
    end

    assign history_o = hist_q;

endmodule

// File: inst_predecode.sv
`timescale 1ns/1ns

module inst_predecode
    import rv_isa_pkg::*;
    import bpu_pkg::*;
(
    input  inst_t       inst_i,
    output inst_class_t class_o
);

    i_type_t f;
    logic    rs1_link;

    assign f = i_type_t'(inst_i);

    // ret is jalr x0, 0(ra) or jalr x0, 0(t0)
    assign rs1_link = (f.rs1 == reg_ra) || (f.rs1 == reg_t0);

    always_comb begin
        class_o.is_branch = (f.opcode == opc_branch);
        class_o.is_jal    = (f.opcode == opc_jal);
        class_o.is_jalr   = (f.opcode == opc_jalr);
        class_o.is_ret    = (f.opcode == opc_jalr) && rs1_link &&
                            (f.rd == reg_zero) && (f.imm == '0);

        // b-type immediate, 13 bits before sign extension
        class_o.b_offset = {{(xlen-13){inst_i[31]}},
                            inst_i[31],
                            inst_i[7],
                            inst_i[30:25],
                            inst_i[11:8],
                            1'b0};

        // j-type immediate, 21 bits
        class_o.j_offset = {{(xlen-21){inst_i[31]}},
                            inst_i[31],
                            inst_i[19:12],
                            inst_i[20],
                            inst_i[30:21],
                            1'b0};
    end

endmodule

// File: bpu_pkg.sv
package bpu_pkg;

    import rv_isa_pkg::*;

    localparam int hist_len         = 16;
    localparam int tag_len          = 10;
    localparam int partial_tag_bits = 6;   // upper tag bits compared on lookup
    localparam int btb_tag_len      = 22;  // pc[31:10]

    localparam int bim_entries  = 512;
    localparam int tage_entries = 256;
    localparam int btb_entries  = 256;

    typedef logic [hist_len-1:0]              hist_t;
    typedef logic [1:0]                       ctr_t;   // bit 1 = predicted direction
    typedef logic [tag_len-1:0]               tag_t;
    typedef logic [btb_tag_len-1:0]           btb_tag_t;
    typedef logic [$clog2(bim_entries)-1:0]   bim_idx_t;
    typedef logic [$clog2(tage_entries)-1:0]  tage_idx_t;
    typedef logic [$clog2(btb_entries)-1:0]   btb_idx_t;

    localparam ctr_t ctr_strong_nt = 2'b00;
    localparam ctr_t ctr_weak_nt   = 2'b01;  // reset value
    localparam ctr_t ctr_weak_t    = 2'b10;
    localparam ctr_t ctr_strong_t  = 2'b11;

    // predecode result
    typedef struct packed {
        logic  is_branch;
        logic  is_jal;
        logic  is_jalr;
        logic  is_ret;
        addr_t b_offset;
        addr_t j_offset;
    } inst_class_t;

    // execute feedback
    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  correct;
        addr_t pc;
        hist_t history;   // history seen at prediction time
        addr_t target;
    } bpu_update_t;

    typedef struct packed {
        logic  is_cf;
        logic  taken;
        addr_t target;
    } bpu_pred_t;

    // saturating step toward the outcome
    function automatic ctr_t ctr_next(ctr_t c, logic taken);
        ctr_t r;
        r = c;
        if (taken && c != ctr_strong_t) begin
            r = c + 2'd1;
        end else if (!taken && c != ctr_strong_nt) begin
            r = c - 2'd1;
        end
        return r;
    endfunction

    function automatic ctr_t ctr_strong(logic taken);
        return taken ? ctr_strong_t : ctr_strong_nt;
    endfunction

    function automatic ctr_t ctr_weak(logic taken);
        return taken ? ctr_weak_t : ctr_weak_nt;
    endfunction

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] addr_t;  // pc or target
    typedef logic [31:0]     inst_t;

    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [11:0] imm12_t;

    // control-flow opcodes
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;

    // link registers per the calling convention
    localparam reg_idx_t reg_zero = 5'd0;
    localparam reg_idx_t reg_ra   = 5'd1;
    localparam reg_idx_t reg_t0   = 5'd5;

    // i-type view, also fits the opcode/rd/rs1 of every other format
    typedef struct packed {
        imm12_t   imm;
        reg_idx_t rs1;
        funct3_t  funct3;
        reg_idx_t rd;
        opcode_t  opcode;
    } i_type_t;

endpackage
